/* Makefile */
TOP = eeprom_wr_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f eeprom_wr.f -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* design/eeprom_pkg.sv */
`include "eeprom_settings.svh"

package eeprom_pkg;

    // host request, sampled with wr or rd
    typedef struct packed {
        logic [`EEPROM_ADDR_W-1:0] addr;
        logic [`EEPROM_DATA_W-1:0] data;
    } eeprom_req_t;

    // host response, valid with ack
    typedef struct packed {
        logic [`EEPROM_DATA_W-1:0] data;
        logic                      nack;    // some byte went unacknowledged
    } eeprom_rsp_t;

    // OP_START also serves as repeated start
    typedef enum logic [1:0] {
        OP_START,
        OP_STOP,
        OP_WRITE,
        OP_READ
    } i2c_op_t;

    typedef struct packed {
        i2c_op_t                   op;
        logic [`EEPROM_DATA_W-1:0] data;
        logic                      last;    // master no-ack after read byte
    } i2c_cmd_t;

    typedef struct packed {
        logic [`EEPROM_DATA_W-1:0] data;
        logic                      nack;    // sampled ack bit, high if missing
    } i2c_res_t;

endpackage

/* design/eeprom_sequencer.sv */
`timescale 1ns/100ps
`include "eeprom_settings.svh"

module eeprom_sequencer
(
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    wr,
    input  logic                    rd,
    input  eeprom_pkg::eeprom_req_t req,
    input  logic                    eng_idle,
    input  logic                    eng_done,
    input  eeprom_pkg::i2c_res_t    eng_res,
    output logic                    busy,
    output logic                    ack,
    output eeprom_pkg::eeprom_rsp_t rsp,
    output logic                    cmd_go,
    output eeprom_pkg::i2c_cmd_t    cmd
);
    import eeprom_pkg::*;

    typedef enum logic [3:0] {
        S_IDLE,
        S_START,
        S_CTRL_W,
        S_ADDR,
        S_DATA_W,
        S_RESTART,
        S_CTRL_R,
        S_DATA_R,
        S_STOP
    } state_t;

    state_t                    state_q;
    state_t                    next_state;
    logic                      go_pend;     // command of current state not yet issued
    logic                      is_rd_q;
    logic                      nack_q;
    logic                      accept;
    eeprom_req_t               req_q;
    logic [`EEPROM_DATA_W-1:0] rd_q;

    assign busy   = state_q != S_IDLE;
    assign accept = (state_q == S_IDLE) && (wr || rd);
    assign cmd_go = go_pend && eng_idle;

    // step taken when the engine reports done
    always_comb
    begin
        case (state_q)
            S_START:
                next_state = S_CTRL_W;
            S_CTRL_W:
                next_state = eng_res.nack ? S_STOP : S_ADDR;
            S_ADDR:
            begin
                if (eng_res.nack)
                    next_state = S_STOP;
                else if (is_rd_q)
                    next_state = S_RESTART;
                else
                    next_state = S_DATA_W;
            end
            S_RESTART:
                next_state = S_CTRL_R;
            S_CTRL_R:
                next_state = eng_res.nack ? S_STOP : S_DATA_R;
            S_DATA_W,
            S_DATA_R:
                next_state = S_STOP;
            default:
                next_state = S_IDLE;
        endcase
    end

    always_comb
    begin
        cmd.op   = OP_START;
        cmd.data = '0;
        cmd.last = 1'b0;
        case (state_q)
            S_CTRL_W:
            begin
                cmd.op   = OP_WRITE;
                cmd.data = {`EEPROM_DEV_CODE, req_q.addr[`EEPROM_ADDR_W-1:8], 1'b0};
            end
            S_ADDR:
            begin
                cmd.op   = OP_WRITE;
                cmd.data = req_q.addr[7:0];
            end
            S_DATA_W:
            begin
                cmd.op   = OP_WRITE;
                cmd.data = req_q.data;
            end
            S_CTRL_R:
            begin
                cmd.op   = OP_WRITE;
                cmd.data = {`EEPROM_DEV_CODE, req_q.addr[`EEPROM_ADDR_W-1:8], 1'b1};
            end
            S_DATA_R:
            begin
                cmd.op   = OP_READ;
                cmd.last = 1'b1;    // single byte, end with no-ack
            end
            S_STOP:
                cmd.op = OP_STOP;
            default:
                cmd.op = OP_START;  // start and restart
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state_q <= S_IDLE;
            go_pend <= 1'b0;
            ack     <= 1'b0;
            is_rd_q <= 1'b0;
            nack_q  <= 1'b0;
        end
        else
        begin
            ack <= 1'b0;
            if (cmd_go)
            begin
                go_pend <= 1'b0;
            end
            if (accept)
            begin
                is_rd_q <= !wr;     // wr wins
                nack_q  <= 1'b0;
                go_pend <= 1'b1;
                state_q <= S_START;
            end
            else if (busy && eng_done)
            begin
                nack_q  <= nack_q | eng_res.nack;
                go_pend <= next_state != S_IDLE;
                ack     <= state_q == S_STOP;
                state_q <= next_state;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            req_q <= req;
            rd_q  <= '0;
        end
        if (eng_done && state_q == S_DATA_R)
        begin
            rd_q <= eng_res.data;
        end
        if (eng_done && state_q == S_STOP)
        begin
            rsp.data <= rd_q;
            rsp.nack <= nack_q;
        end
    end

endmodule

/* design/eeprom_settings.svh */
`ifndef EEPROM_SETTINGS_SVH
`define EEPROM_SETTINGS_SVH

// CLK cycles per SCL half period, 2 or more
`define EEPROM_SCL_HALF 4

// 24C16 device type code, upper nibble of the control byte
`define EEPROM_DEV_CODE 4'b1010

// 2 KB array, bits 10:8 go out as block select in the control byte
`define EEPROM_ADDR_W 11

`define EEPROM_DATA_W 8

`endif

/* design/eeprom_wr.sv */
`timescale 1ns/100ps

module eeprom_wr
(
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    wr,
    input  logic                    rd,
    input  eeprom_pkg::eeprom_req_t req,
    input  logic                    sda_in,
    output logic                    busy,
    output logic                    ack,
    output eeprom_pkg::eeprom_rsp_t rsp,
    output logic                    scl,
    output logic                    sda_oe
);
    import eeprom_pkg::*;

    // sequencer to engine, one command in flight
    logic     eng_idle;
    logic     eng_done;
    i2c_res_t eng_res;
    logic     cmd_go;
    i2c_cmd_t cmd;

    eeprom_sequencer u_seq
    (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .req      (req),
        .eng_idle (eng_idle),
        .eng_done (eng_done),
        .eng_res  (eng_res),
        .busy     (busy),
        .ack      (ack),
        .rsp      (rsp),
        .cmd_go   (cmd_go),
        .cmd      (cmd)
    );

    // open-drain SDA, line resolved outside
    i2c_bit_engine u_eng
    (
        .CLK    (CLK),
        .RESET  (RESET),
        .cmd_go (cmd_go),
        .cmd    (cmd),
        .sda_in (sda_in),
        .idle   (eng_idle),
        .done   (eng_done),
        .res    (eng_res),
        .scl    (scl),
        .sda_oe (sda_oe)
    );

endmodule

/* design/i2c_bit_engine.sv */
`timescale 1ns/100ps
`include "eeprom_settings.svh"

module i2c_bit_engine
(
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 cmd_go,
    input  eeprom_pkg::i2c_cmd_t cmd,
    input  logic                 sda_in,
    output logic                 idle,
    output logic                 done,
    output eeprom_pkg::i2c_res_t res,
    output logic                 scl,
    output logic                 sda_oe
);
    import eeprom_pkg::*;

    localparam int HALF  = `EEPROM_SCL_HALF;
    localparam int CNT_W = (HALF > 2) ? $clog2(HALF) : 1;

    logic [CNT_W-1:0] cnt;      // position inside the half period
    logic [4:0]       hcnt;     // half period index inside the command
    logic             active;

    i2c_op_t          op_q;
    logic [7:0]       tx_q;
    logic             last_q;

    logic [4:0]       hcnt_end;
    logic [3:0]       bit_idx;
    logic             cnt_wrap;
    logic             sample;

    // start and stop take three halves: low, high, high
    // bytes take nine low/high pairs, odd halves are high
    function automatic logic half_scl(input i2c_op_t op, input logic [4:0] h);
        if (op == OP_START || op == OP_STOP)
        begin
            return h != 5'd0;
        end
        return h[0];
    endfunction

    // SDA pull-down for a given half
    function automatic logic half_pull
    (
        input i2c_op_t    op,
        input logic [4:0] h,
        input logic [7:0] tx,
        input logic       last
    );
        logic [3:0] i;
        i = h[4:1];
        case (op)
            OP_START:
                return h == 5'd2;                   // falls mid third half
            OP_STOP:
                return h != 5'd2;                   // rises mid third half
            OP_WRITE:
                return (i < 4'd8) ? !tx[3'd7 - i[2:0]] : 1'b0;
            default:
                return (i == 4'd8) ? !last : 1'b0;  // ack unless last
        endcase
    endfunction

    assign idle     = !active;
    assign hcnt_end = (op_q == OP_START || op_q == OP_STOP) ? 5'd2 : 5'd17;
    assign cnt_wrap = cnt == CNT_W'(HALF - 1);
    assign bit_idx  = hcnt[4:1];

    // first cycle of a high half, right after the rising edge
    assign sample = active && hcnt[0] && (cnt == '0) &&
                    (op_q == OP_WRITE || op_q == OP_READ);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active <= 1'b0;
            done   <= 1'b0;
            scl    <= 1'b1;
            sda_oe <= 1'b0;
            cnt    <= '0;
            hcnt   <= '0;
        end
        else
        begin
            done <= 1'b0;
            if (!active)
            begin
                if (cmd_go)
                begin
                    active <= 1'b1;
                    cnt    <= '0;
                    hcnt   <= '0;
                    scl    <= half_scl(cmd.op, 5'd0);
                end
            end
            else
            begin
                if (cnt_wrap)
                begin
                    cnt  <= '0;
                    hcnt <= hcnt + 5'd1;
                    scl  <= half_scl(op_q, hcnt + 5'd1);
                end
                else
                begin
                    cnt <= cnt + CNT_W'(1);
                end

                // SDA moves one cycle after SCL so it never races the edge
                if (cnt == '0)
                begin
                    sda_oe <= half_pull(op_q, hcnt, tx_q, last_q);
                end

                // done lands on the last cycle of the final half
                if (hcnt == hcnt_end && cnt == CNT_W'(HALF - 2))
                begin
                    active <= 1'b0;
                    done   <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (!active && cmd_go)
        begin
            op_q     <= cmd.op;
            tx_q     <= cmd.data;
            last_q   <= cmd.last;
            res.nack <= 1'b0;
        end
        else if (sample)
        begin
            if (op_q == OP_READ && bit_idx < 4'd8)
            begin
                res.data <= {res.data[6:0], sda_in};    // msb first
            end
            if (op_q == OP_WRITE && bit_idx == 4'd8)
            begin
                res.nack <= sda_in;
            end
        end
    end

endmodule

/* eeprom_wr.f */
+incdir+design
design/eeprom_pkg.sv
design/i2c_bit_engine.sv
design/eeprom_sequencer.sv
design/eeprom_wr.sv
sim/eeprom_model.sv
sim/eeprom_wr_chk.sv
sim/eeprom_wr_tb.sv

/* sim/eeprom_model.sv */
`timescale 1ns/100ps

module eeprom_model
(
    input  logic CLK,
    input  logic RESET,
    input  logic enable,
    input  logic scl,
    input  logic sda_in,
    output logic sda_oe
);
    typedef enum logic [1:0] {
        M_IDLE,
        M_RX,
        M_TX
    } mstate_t;

    logic [7:0] mem [0:2047];

    mstate_t    state;
    logic       scl_q;
    logic       sda_q;
    logic [3:0] bitcnt;
    logic [1:0] byte_no;     // 0 control, 1 address, 2 data
    logic [7:0] sh;
    logic [7:0] tx;
    logic [7:0] wdata;
    logic [2:0] blk;
    logic [7:0] lo;
    logic       ack_q;
    logic       to_tx;
    logic       wpend;       // data byte waiting for stop
    logic       ack_now;
    logic       start_c;
    logic       stop_c;
    logic       rise;
    logic       fall;

    assign start_c = scl && scl_q && sda_q && !sda_in;
    assign stop_c  = scl && scl_q && !sda_q && sda_in;
    assign rise    = scl && !scl_q;
    assign fall    = !scl && scl_q;
    assign ack_now = enable && (byte_no != 2'd0 || sh[7:4] == 4'b1010);

    initial
    begin
        for (int i = 0; i < 2048; i++)
        begin
            mem[i] = 8'hFF;  // erased part
        end
    end

    always @(posedge CLK)
    begin
        scl_q <= scl;
        sda_q <= sda_in;
        if (RESET)
        begin
            state  <= M_IDLE;
            sda_oe <= 1'b0;
            bitcnt <= 4'd0;
            wpend  <= 1'b0;
            to_tx  <= 1'b0;
            blk    <= 3'd0;
            lo     <= 8'd0;
        end
        else if (start_c)
        begin
            state   <= M_RX;
            bitcnt  <= 4'd0;
            byte_no <= 2'd0;
            to_tx   <= 1'b0;
            wpend   <= 1'b0;
            sda_oe  <= 1'b0;
        end
        else if (stop_c)
        begin
            if (wpend)
            begin
                mem[{blk, lo}] <= wdata;
            end
            wpend  <= 1'b0;
            state  <= M_IDLE;
            sda_oe <= 1'b0;
        end
        else if (rise && state != M_IDLE)
        begin
            if (state == M_RX && bitcnt < 4'd8)
            begin
                sh <= {sh[6:0], sda_in};
            end
            bitcnt <= bitcnt + 4'd1;
        end
        else if (fall && state == M_RX)
        begin
            if (bitcnt == 4'd8)
            begin
                sda_oe <= ack_now;   // ack clock
                ack_q  <= ack_now;
                if (ack_now && byte_no == 2'd0)
                begin
                    if (sh[0])
                        to_tx <= 1'b1;
                    else
                        blk <= sh[3:1];
                end
                if (ack_now && byte_no == 2'd1)
                begin
                    lo <= sh;
                end
                if (ack_now && byte_no == 2'd2)
                begin
                    wdata <= sh;
                    wpend <= 1'b1;
                end
            end
            else if (bitcnt == 4'd9)
            begin
                bitcnt <= 4'd0;
                if (!ack_q)
                begin
                    state  <= M_IDLE;
                    sda_oe <= 1'b0;
                end
                else if (to_tx)
                begin
                    state  <= M_TX;
                    tx     <= mem[{blk, lo}];
                    sda_oe <= !mem[{blk, lo}][7];
                end
                else
                begin
                    sda_oe <= 1'b0;
                    if (byte_no != 2'd2)
                        byte_no <= byte_no + 2'd1;
                end
            end
        end
        else if (fall && state == M_TX)
        begin
            if (bitcnt < 4'd8)
                sda_oe <= !tx[3'd7 - bitcnt[2:0]];
            else if (bitcnt == 4'd8)
                sda_oe <= 1'b0;      // master ack slot
            else
            begin
                state  <= M_IDLE;
                sda_oe <= 1'b0;
            end
        end
    end

endmodule

/* sim/eeprom_stimulus.txt */
# op addr data: W write, R read and expect data, B write plus ignored rd
# E flag: slave model enable (1 on, 0 off)
W 012 a5
R 012 a5
W 112 3c
W 212 c3
W 712 7e
R 012 a5
R 112 3c
R 212 c3
R 712 7e
R 345 ff
E 0
W 012 00
R 012 00
E 1
R 012 a5
B 456 99
R 456 99

/* sim/eeprom_wr_chk.sv */
`timescale 1ns/100ps
`include "eeprom_settings.svh"

module eeprom_wr_chk
(
    input logic CLK,
    input logic RESET,
    input logic busy,
    input logic ack,
    input logic scl,
    input logic sda_in,
    input logic sda_oe
);
    localparam int HALF = `EEPROM_SCL_HALF;

    logic rst_q = 1'b0;
    logic fail_seen = 1'b0;     // sticky, any assertion below failed

    always @(posedge CLK)
    begin
        rst_q <= RESET;
    end

    ack_one_cycle: assert property (@(posedge CLK) disable iff (RESET) ack |=> !ack)
        else
        begin
            fail_seen = 1'b1;
            $error("ack held longer than one cycle");
        end

    ack_with_busy: assert property (@(posedge CLK) disable iff (RESET) $fell(busy) |-> ack)
        else
        begin
            fail_seen = 1'b1;
            $error("busy fell without ack");
        end

    // start and stop edges come only after SCL sat high a full half
    sda_vs_scl: assert property (@(posedge CLK) disable iff (RESET)
        scl && $past(scl) && $changed(sda_in) |-> $changed(sda_oe) && $past(scl, HALF))
        else
        begin
            fail_seen = 1'b1;
            $error("SDA changed while SCL high outside start or stop");
        end

    quiet_reset: assert property (@(posedge CLK) RESET && rst_q |-> !sda_oe)
        else
        begin
            fail_seen = 1'b1;
            $error("sda_oe active during reset");
        end

endmodule

bind eeprom_wr eeprom_wr_chk u_chk
(
    .CLK    (CLK),
    .RESET  (RESET),
    .busy   (busy),
    .ack    (ack),
    .scl    (scl),
    .sda_in (sda_in),
    .sda_oe (sda_oe)
);

/* sim/eeprom_wr_tb.sv */
`timescale 1ns/100ps

module eeprom_wr_tb;
    import eeprom_pkg::*;

    logic        CLK;
    logic        RESET;
    logic        wr;
    logic        rd;
    eeprom_req_t req;
    logic        sda_in;
    logic        busy;
    logic        ack;
    eeprom_rsp_t rsp;
    logic        scl;
    logic        sda_oe;
    logic        model_sda_oe;
    logic        model_en;
    int          ack_count = 0;
    int          acks_expected;

    assign sda_in = !(sda_oe || model_sda_oe);  // wired-AND

    eeprom_wr dut
    (
        .CLK    (CLK),
        .RESET  (RESET),
        .wr     (wr),
        .rd     (rd),
        .req    (req),
        .sda_in (sda_in),
        .busy   (busy),
        .ack    (ack),
        .rsp    (rsp),
        .scl    (scl),
        .sda_oe (sda_oe)
    );

    eeprom_model u_model
    (
        .CLK    (CLK),
        .RESET  (RESET),
        .enable (model_en),
        .scl    (scl),
        .sda_in (sda_in),
        .sda_oe (model_sda_oe)
    );

    initial
    begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    task automatic fail_now;
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    always @(negedge CLK)
    begin
        if (ack)
            ack_count++;
        assert (!dut.u_chk.fail_seen)
        else
        begin
            $display("a bus or ack assertion in the bound checker failed");
            fail_now();
        end
        // idle bus whenever the controller is free
        if (!RESET && !busy)
        begin
            assert (scl === 1'b1 && sda_in === 1'b1)
            else
            begin
                $display("error: idle bus scl %h sda_in %h expected 1 1", scl, sda_in);
                fail_now();
            end
        end
    end

    task automatic wait_ack;
        int n;
        n = 0;
        @(negedge CLK);
        while (!ack)
        begin
            if (n >= 2000)
            begin
                $display("timeout: no ack within 2000 cycles");
                fail_now();
            end
            @(negedge CLK);
            n++;
        end
    endtask

    task automatic check_acks;
        assert (ack_count == acks_expected)
        else
        begin
            $display("error: ack count %h expected %h", ack_count, acks_expected);
            fail_now();
        end
    endtask

    task automatic check_rsp(input logic [7:0] exp_data, input logic cmp_data);
        assert (rsp.nack == !model_en)
        else
        begin
            $display("error: rsp.nack %h expected %h", rsp.nack, !model_en);
            fail_now();
        end
        assert (!cmp_data || rsp.data == exp_data)
        else
        begin
            $display("error: rsp.data %h expected %h", rsp.data, exp_data);
            fail_now();
        end
    endtask

    task automatic issue(input logic is_wr, input logic [10:0] addr, input logic [7:0] data);
        @(negedge CLK);
        check_acks();
        assert (!busy)
        else
        begin
            $display("controller still busy when a new request was issued");
            fail_now();
        end
        req.addr = addr;
        req.data = data;
        wr = is_wr;
        rd = !is_wr;
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
        assert (busy)
        else
        begin
            $display("controller did not turn busy the cycle after the request");
            fail_now();
        end
        acks_expected++;
    endtask

    initial
    begin
        int          fd;
        logic [7:0]  op;
        logic [10:0] addr;
        logic [7:0]  data;
        string       line;
        RESET = 1'b1;
        wr = 1'b0;
        rd = 1'b0;
        req = '0;
        model_en = 1'b1;
        acks_expected = 0;
        repeat (16) @(negedge CLK);
        RESET = 1'b0;
        fd = $fopen("sim/eeprom_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open the stimulus file");
            fail_now();
        end
        while ($fscanf(fd, " %c", op) == 1)
        begin
            case (op)
                "#": void'($fgets(line, fd));
                "W":
                begin
                    void'($fscanf(fd, "%h %h", addr, data));
                    issue(1'b1, addr, data);
                    wait_ack();
                    check_rsp(8'h00, 1'b0);
                end
                "R":
                begin
                    void'($fscanf(fd, "%h %h", addr, data));
                    issue(1'b0, addr, 8'h00);
                    wait_ack();
                    check_rsp(data, model_en);
                end
                "E":
                begin
                    void'($fscanf(fd, "%h", data));
                    @(negedge CLK);
                    model_en = data[0];
                end
                "B":
                begin
                    void'($fscanf(fd, "%h %h", addr, data));
                    issue(1'b1, addr, data);
                    @(negedge CLK);
                    assert (busy)
                    else
                    begin
                        $display("controller not busy when the extra rd strobe came");
                        fail_now();
                    end
                    rd = 1'b1;   // must be dropped
                    @(negedge CLK);
                    rd = 1'b0;
                    wait_ack();
                    check_rsp(8'h00, 1'b0);
                end
                default:
                begin
                    $display("unknown operation in the stimulus file");
                    fail_now();
                end
            endcase
        end
        $fclose(fd);
        repeat (4) @(negedge CLK);
        check_acks();
        $display("Simulation PASSED");
        $finish;
    end

endmodule
